// File: filelist.f
rtl/spi_pkg.sv
rtl/spi_sync.sv
rtl/spi_shift_engine.sv
rtl/spi_reg_port.sv
rtl/spi_minion_top.sv
tb/spi_minion_checker.sv
tb/tb_spi_minion.sv

// File: tb/tb_spi_minion.sv
// ----------------------------------------------------------------------
// Testbench for the SPI mode-0 minion with 16-bit frames at 6 clocks
// per sclk half-period. A reference model of the register bank predicts
// the miso word of each frame from the frame before it.
// sclk and mosi also toggle while cs is high between frames.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_spi_minion;
  import spi_pkg::*;

  localparam int half_clks    = 6;
  localparam int evt_timeout  = 20;
  localparam int cs_idle_clks = 8;

  // One frame of stimulus with its expected write flag
  typedef struct packed {
    logic [1:0] cmd;
    logic [3:0] addr;
    logic [9:0] data;
    logic       exp_wr;
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       cs;
  logic       sclk;
  logic       mosi;
  logic       miso;
  frame_evt_t frame_evt;

  row_t        table_q[$];
  logic [9:0]  model_regs [16];
  logic [15:0] exp_reply;
  integer      seed;
  int          n_checks;
  int          n_errors;
  int          row_errors;

  spi_minion_top #(
    .sync_stages (2)
  ) i_spi_minion_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cs        (cs),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso      (miso),
    .frame_evt (frame_evt)
  );

  bind spi_minion_top spi_minion_checker i_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_en   (push_en),
    .pull_en   (i_shift_engine.pull_en),
    .cs_level  (cs_pin.level),
    .evt_valid (frame_evt.valid),
    .push_msg  (push_msg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  // Drive and sample 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      row_errors++;
      $display("ERROR %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic add_row(input logic [1:0] cmd, input logic [3:0] addr,
                         input logic [9:0] data, input logic exp_wr);
    table_q.push_back('{cmd: cmd, addr: addr, data: data, exp_wr: exp_wr});
  endtask

  // Host side of one mode-0 frame sent MSB first
  task automatic spi_transfer(input logic [15:0] tx, output logic [15:0] rx);
    rx   = '0;
    cs   = 1'b0;
    sclk = 1'b0;
    mosi = tx[15];
    repeat (half_clks) step();
    for (int i = 15; i >= 0; i--) begin
      sclk  = 1'b1;
      rx[i] = miso;
      repeat (half_clks) step();
      sclk = 1'b0;
      if (i > 0) begin
        mosi = tx[i-1];
      end
      repeat (half_clks) step();
    end
    cs   = 1'b1;
    mosi = 1'b0;
  endtask

  // One sclk pulse with mosi high while the minion is deselected
  task automatic toggle_deselected();
    mosi = 1'b1;
    sclk = 1'b1;
    repeat (half_clks) step();
    sclk = 1'b0;
    mosi = 1'b0;
    repeat (half_clks) step();
  endtask

  task automatic wait_frame_evt(output logic seen);
    seen = 1'b0;
    for (int n = 0; n < evt_timeout && !seen; n++) begin
      step();
      if (frame_evt.valid) begin
        seen = 1'b1;
      end
    end
  endtask

  // Reply rule and register writes of the reference model
  task automatic update_model(input row_t r, input logic [15:0] word);
    case (r.cmd)
      cmd_write: begin
        model_regs[r.addr] = r.data;
        exp_reply          = word;
      end
      cmd_read: begin
        exp_reply = {cmd_read, r.addr, model_regs[r.addr]};
      end
      cmd_echo: begin
        exp_reply = word;
      end
      default: begin
        // NOP keeps the reply
      end
    endcase
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    // Every register reads 0 after reset
    for (int a = 0; a < 16; a++) begin
      add_row(cmd_read, a[3:0], 10'h000, 1'b0);
    end
    // Write then read back
    add_row(cmd_write, 4'h5, 10'h2a5, 1'b1);
    add_row(cmd_read,  4'h5, 10'h000, 1'b0);
    // Echo patterns with all ones, alternating bits and a zero payload
    add_row(cmd_echo, 4'hf, 10'h3ff, 1'b0);
    add_row(cmd_echo, 4'h5, 10'h155, 1'b0);
    add_row(cmd_echo, 4'ha, 10'h2aa, 1'b0);
    add_row(cmd_echo, 4'h0, 10'h000, 1'b0);
    // NOPs leave reply and registers alone
    add_row(cmd_nop,  4'h5, 10'h3c3, 1'b0);
    add_row(cmd_nop,  4'h2, 10'h0f0, 1'b0);
    add_row(cmd_read, 4'h5, 10'h000, 1'b0);
    // Random data to every address
    for (int a = 0; a < 16; a++) begin
      rnd = $random(seed);
      add_row(cmd_write, a[3:0], rnd[9:0], 1'b1);
      add_row(cmd_read,  a[3:0], 10'h000,  1'b0);
    end
    // Flush the last reply
    add_row(cmd_nop, 4'h0, 10'h000, 1'b0);
  endtask

  task automatic finish_run(input int n_tests);
    if (i_spi_minion_top.i_checker.n_fail != 0) begin
      $display("Checker assertions failed %0d times",
               i_spi_minion_top.i_checker.n_fail);
      n_errors += i_spi_minion_top.i_checker.n_fail;
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial begin : main
    row_t        row;
    logic [15:0] tx;
    logic [15:0] rx;
    logic        seen;
    int          n_tests;

    seed       = 32'hf1df926e;
    rst_n      = 1'b0;
    cs         = 1'b1;
    sclk       = 1'b0;
    mosi       = 1'b0;
    exp_reply  = '0;
    n_checks   = 0;
    n_errors   = 0;
    row_errors = 0;
    n_tests    = 0;
    for (int a = 0; a < 16; a++) begin
      model_regs[a] = '0;
    end
    build_table();

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (cs_idle_clks) step();

    foreach (table_q[idx]) begin
      row        = table_q[idx];
      tx         = {row.cmd, row.addr, row.data};
      row_errors = 0;
      spi_transfer(tx, rx);
      wait_frame_evt(seen);
      if (!seen) begin
        $display("Timeout: no frame event after test %0d (frame 0x%h)", idx, tx);
        n_errors++;
        break;
      end
      check_value("miso word", rx, exp_reply);
      check_value("frame_evt.frame", frame_evt.frame.raw, tx);
      check_value("frame_evt.parity", frame_evt.parity, ^tx[13:0]);
      check_value("frame_evt.reg_wr", frame_evt.reg_wr, row.exp_wr);
      update_model(row, tx);
      n_tests++;
      $display("test %0d: cmd %0d addr %0d data 0x%h tx 0x%h rx 0x%h: %s",
               idx, row.cmd, row.addr, row.data, tx, rx,
               (row_errors == 0) ? "ok" : "mismatch");
      toggle_deselected();
      repeat (cs_idle_clks) step();
    end

    finish_run(n_tests);
  end

endmodule

`default_nettype wire

// File: tb/spi_minion_checker.sv
// ----------------------------------------------------------------------
// Concurrent checks on the minion strobes and frame event timing.
// Bound into spi_minion_top; pull_en is taken from the shift engine.
// Checks are disabled while rst_n is low.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_minion_checker
  import spi_pkg::*;
(
  input wire logic clk,
  input wire logic rst_n,
  input wire logic push_en,
  input wire logic pull_en,
  input wire logic cs_level,
  input wire logic evt_valid,
  input spi_frame_u push_msg
);

  // Number of assertion failures so far
  int n_fail = 0;

  // ------------------------------------------------------------------
  // Frame strobes
  // ------------------------------------------------------------------

  // Both come from opposite cs edges
  a_strobe_excl: assert property (
    @(posedge clk) disable iff (!rst_n) !(push_en && pull_en)
  ) else begin
    n_fail++;
    $error("push_en and pull_en high in the same cycle");
  end

  // ------------------------------------------------------------------
  // Frame event timing
  // ------------------------------------------------------------------

  a_evt_follows_push: assert property (
    @(posedge clk) disable iff (!rst_n) push_en |=> evt_valid
  ) else begin
    n_fail++;
    $error("frame_evt.valid missing one clock after push_en");
  end

  a_evt_has_cause: assert property (
    @(posedge clk) disable iff (!rst_n) evt_valid |-> $past(push_en)
  ) else begin
    n_fail++;
    $error("frame_evt.valid without push_en in the cycle before");
  end

  a_evt_single: assert property (
    @(posedge clk) disable iff (!rst_n) evt_valid |=> !evt_valid
  ) else begin
    n_fail++;
    $error("frame_evt.valid high for two cycles");
  end

  // Receive register is frozen while deselected
  a_rx_frozen: assert property (
    @(posedge clk) disable iff (!rst_n) cs_level |=> $stable(push_msg)
  ) else begin
    n_fail++;
    $error("input shift register changed while cs high");
  end

endmodule

`default_nettype wire

// File: rtl/spi_minion_top.sv
// ----------------------------------------------------------------------
// SPI mode-0 minion with a 16 x 10-bit register bank.
// Runs on clk; cs, sclk and mosi are asynchronous inputs.
// Each sclk half-period must last at least sync_stages+2 clocks.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_minion_top
  import spi_pkg::*;
#(
  parameter int unsigned sync_stages = 2
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic cs,
  input  wire logic sclk,
  input  wire logic mosi,
  output logic      miso,
  output frame_evt_t frame_evt
);

  spi_pin_t   cs_pin;
  spi_pin_t   sclk_pin;
  spi_pin_t   mosi_pin;
  logic       push_en;
  spi_frame_u push_msg;
  spi_frame_u reply;

  // ------------------------------------------------------------------
  // Pin synchronizers
  // ------------------------------------------------------------------

  // cs idles high
  spi_sync #(
    .sync_stages (sync_stages),
    .rst_val     (1'b1)
  ) i_cs_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .pin   (cs),
    .sync  (cs_pin)
  );

  spi_sync #(
    .sync_stages (sync_stages),
    .rst_val     (1'b0)
  ) i_sclk_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .pin   (sclk),
    .sync  (sclk_pin)
  );

  spi_sync #(
    .sync_stages (sync_stages),
    .rst_val     (1'b0)
  ) i_mosi_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .pin   (mosi),
    .sync  (mosi_pin)
  );

  // ------------------------------------------------------------------
  // Shift engine and register port
  // ------------------------------------------------------------------

  spi_shift_engine i_shift_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .cs_pin   (cs_pin),
    .sclk_pin (sclk_pin),
    .mosi_pin (mosi_pin),
    .reply    (reply),
    .miso     (miso),
    .push_en  (push_en),
    .push_msg (push_msg)
  );

  spi_reg_port i_reg_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_en   (push_en),
    .push_msg  (push_msg),
    .reply     (reply),
    .frame_evt (frame_evt)
  );

endmodule

`default_nettype wire

// File: rtl/spi_reg_port.sv
// ----------------------------------------------------------------------
// Frame decoder and register bank behind the SPI port.
// Sixteen 10-bit registers; reply is used during the following frame.
// Write, reply update and frame event all land one clock after push_en.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_reg_port
  import spi_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic push_en,
  input  spi_frame_u push_msg,
  output spi_frame_u reply,
  output frame_evt_t frame_evt
);

  logic [data_w-1:0] regs [n_regs];

  logic              wr_en;
  logic [data_w-1:0] rd_data;
  logic              payload_parity;
  spi_frame_u        reply_next;

  // ------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------

  assign wr_en   = push_en && (push_msg.fields.cmd == cmd_write);
  assign rd_data = regs[push_msg.fields.addr];

  // Parity covers addr and data, not the command
  assign payload_parity = ^{push_msg.fields.addr, push_msg.fields.data};

  // ------------------------------------------------------------------
  // Register bank
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < n_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[push_msg.fields.addr] <= push_msg.fields.data;
    end
  end

  // ------------------------------------------------------------------
  // Reply word
  // ------------------------------------------------------------------

  always_comb begin
    reply_next = reply;
    unique case (push_msg.fields.cmd)
      cmd_write: begin
        // Frame as received, carries the data just written
        reply_next = push_msg;
      end
      cmd_read: begin
        reply_next.fields.cmd  = cmd_read;
        reply_next.fields.addr = push_msg.fields.addr;
        reply_next.fields.data = rd_data;
      end
      cmd_echo: begin
        reply_next.raw = push_msg.raw;
      end
      cmd_nop: begin
        reply_next = reply;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reply.raw <= '0;
    end else if (push_en) begin
      reply <= reply_next;
    end
  end

  // ------------------------------------------------------------------
  // Frame event
  // ------------------------------------------------------------------

  // valid is a single-cycle pulse, other fields hold until next frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_evt.valid     <= 1'b0;
      frame_evt.frame.raw <= '0;
      frame_evt.parity    <= 1'b0;
      frame_evt.reg_wr    <= 1'b0;
    end else begin
      frame_evt.valid <= push_en;
      if (push_en) begin
        frame_evt.frame  <= push_msg;
        frame_evt.parity <= payload_parity;
        frame_evt.reg_wr <= wr_en;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/spi_shift_engine.sv
// ----------------------------------------------------------------------
// Mode-0 shift engine (CPOL 0, CPHA 0), 16-bit frames only.
// Inputs are synchronized pin states; edges act only while cs is low.
// Reply must be stable when cs falls, it is loaded on that edge.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_shift_engine
  import spi_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  spi_pin_t        cs_pin,
  input  spi_pin_t        sclk_pin,
  input  spi_pin_t        mosi_pin,
  input  spi_frame_u      reply,
  output logic            miso,
  output logic            push_en,
  output spi_frame_u      push_msg
);

  logic       pull_en;
  logic       shift_in_en;
  logic       shift_out_en;
  spi_frame_u shift_in;
  spi_frame_u shift_out;

  // Frame strobes straight from the cs edges
  assign pull_en = cs_pin.fall;
  assign push_en = cs_pin.rise;

  // Sample on sclk rise, drive on sclk fall
  assign shift_in_en  = ~cs_pin.level & sclk_pin.rise;
  assign shift_out_en = ~cs_pin.level & sclk_pin.fall;

  // ------------------------------------------------------------------
  // Receive register
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_in.raw <= '0;
    end else if (shift_in_en) begin
      shift_in.raw <= {shift_in.raw[frame_w-2:0], mosi_pin.level};
    end
  end

  assign push_msg = shift_in;

  // ------------------------------------------------------------------
  // Transmit register
  // ------------------------------------------------------------------

  // Load wins over shift, both cannot occur in one cycle anyway
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_out.raw <= '0;
    end else if (pull_en) begin
      shift_out <= reply;
    end else if (shift_out_en) begin
      shift_out.raw <= {shift_out.raw[frame_w-2:0], 1'b0};
    end
  end

  // MSB first
  assign miso = shift_out.raw[frame_w-1];

endmodule

`default_nettype wire

// File: rtl/spi_sync.sv
// ----------------------------------------------------------------------
// Synchronizer for one asynchronous pin with edge detection.
// Output changes sync_stages+1 clocks after the pin; needs sync_stages >= 1.
// All flops reset to rst_val so no edge is reported after reset.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_sync
  import spi_pkg::*;
#(
  parameter int unsigned sync_stages = 2,
  parameter logic        rst_val     = 1'b0
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic pin,
  output spi_pin_t  sync
);

  // Metastability chain, index 0 sees the raw pin
  logic [sync_stages-1:0] chain;
  logic                   stable;

  assign stable = chain[sync_stages-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chain <= {sync_stages{rst_val}};
    end else begin
      chain[0] <= pin;
      for (int i = 1; i < sync_stages; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  // sync.level doubles as the history flop for edge detection
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync.level <= rst_val;
      sync.rise  <= 1'b0;
      sync.fall  <= 1'b0;
    end else begin
      sync.level <= stable;
      sync.rise  <= stable & ~sync.level;
      sync.fall  <= ~stable & sync.level;
    end
  end

endmodule

`default_nettype wire

// File: rtl/spi_pkg.sv
// ----------------------------------------------------------------------
// Shared types and constants for the SPI mode-0 minion.
// Frame and field widths are fixed here and are not parameters.
// Frame layout from MSB down: cmd, addr, data.
// ----------------------------------------------------------------------
`default_nettype none

package spi_pkg;

  // Frame geometry
  localparam int frame_w = 16;
  localparam int cmd_w   = 2;
  localparam int addr_w  = 4;
  localparam int data_w  = 10;
  localparam int n_regs  = 16;

  // Command codes
  localparam logic [cmd_w-1:0] cmd_nop   = 2'd0;
  localparam logic [cmd_w-1:0] cmd_write = 2'd1;
  localparam logic [cmd_w-1:0] cmd_read  = 2'd2;
  localparam logic [cmd_w-1:0] cmd_echo  = 2'd3;

  typedef struct packed {
    logic [cmd_w-1:0]  cmd;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } spi_fields_t;

  // Same word seen raw (shifting, ECHO) or split into fields (decode)
  typedef union packed {
    logic [frame_w-1:0] raw;
    spi_fields_t        fields;
  } spi_frame_u;

  // Synchronized pin state, edges are one-clock pulses
  typedef struct packed {
    logic level;
    logic rise;
    logic fall;
  } spi_pin_t;

  // One report per received frame
  typedef struct packed {
    logic       valid;
    spi_frame_u frame;
    logic       parity;
    logic       reg_wr;
  } frame_evt_t;

endpackage

`default_nettype wire
